// ==== logic/lc3b_pkg.sv ====
package lc3b_pkg;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [2:0] lc3b_nzp;

// opcodes kept by this core, anything else retires as a nop
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_not = 4'b1001,
	op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add  = 2'b00,
	alu_and  = 2'b01,
	alu_not  = 2'b10,
	// address adder result, for lea
	alu_pass = 2'b11
} lc3b_alu_op;

localparam int num_regs = 8;

// br with nzp 000, never taken
localparam lc3b_word nop_instr = 16'h0000;

// forwarding selects for the execute operands
localparam logic [1:0] fwd_reg = 2'd0;
localparam logic [1:0] fwd_mem = 2'd1;
localparam logic [1:0] fwd_wb = 2'd2;

endpackage : lc3b_pkg

// ==== logic/lc3b_fetch.sv ====
`timescale 1ns/1ns

module lc3b_fetch import lc3b_pkg::*; #(
	parameter lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic arst_n,
	input lc3b_word fetch_instr,
	input logic redirect,
	input lc3b_word redirect_pc,
	output lc3b_word fetch_addr,
	output logic if_valid,
	output lc3b_word if_instr,
	output lc3b_word if_pc
);

// fetch_addr is the pc itself
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		fetch_addr <= reset_pc;
		if_valid <= 1'b0;
		if_instr <= nop_instr;
		if_pc <= reset_pc;
	end else if (redirect) begin
		// taken branch, drop whatever was fetched this cycle
		fetch_addr <= redirect_pc;
		if_valid <= 1'b0;
	end else begin
		fetch_addr <= fetch_addr + 16'd2;
		if_valid <= 1'b1;
		if_instr <= fetch_instr;
		if_pc <= fetch_addr;
	end
end

endmodule : lc3b_fetch

// ==== logic/lc3b_regfile.sv ====
`timescale 1ns/1ns

module lc3b_regfile import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	input logic wr_en,
	input lc3b_reg wr_reg,
	input lc3b_word wr_data,
	output lc3b_word rd_a,
	output lc3b_word rd_b
);

lc3b_word regs [num_regs];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < num_regs; i++)
			regs[i] <= '0;
	end else if (wr_en) begin
		regs[wr_reg] <= wr_data;
	end
end

// write-through so decode sees the retiring value
assign rd_a = (wr_en && wr_reg == src_a) ? wr_data : regs[src_a];
assign rd_b = (wr_en && wr_reg == src_b) ? wr_data : regs[src_b];

endmodule : lc3b_regfile

// ==== logic/lc3b_decode.sv ====
`timescale 1ns/1ns

module lc3b_decode import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic if_valid,
	input lc3b_word if_instr,
	input lc3b_word if_pc,
	input lc3b_word rd_a,
	input lc3b_word rd_b,
	input logic flush,
	output lc3b_reg src_a,
	output lc3b_reg src_b,
	output lc3b_reg ex_sr1,
	output lc3b_reg ex_sr2,
	output lc3b_reg ex_dest,
	output lc3b_word ex_a,
	output lc3b_word ex_b,
	output lc3b_word ex_imm,
	output lc3b_word ex_offset,
	output lc3b_word ex_pc,
	output logic ex_valid,
	output logic ex_use_imm,
	output logic ex_writes,
	output logic ex_sets_cc,
	output logic ex_is_br,
	output lc3b_nzp ex_nzp,
	output lc3b_alu_op ex_alu_op
);

lc3b_opcode opcode;
lc3b_word imm5;
lc3b_word offset9;
logic use_imm;
logic writes;
logic sets_cc;
logic is_br;
lc3b_alu_op alu_op;

assign opcode = lc3b_opcode'(if_instr[15:12]);
assign src_a = if_instr[8:6];
assign src_b = if_instr[2:0];
assign imm5 = {{11{if_instr[4]}}, if_instr[4:0]};
// offset9 already in bytes
assign offset9 = {{6{if_instr[8]}}, if_instr[8:0], 1'b0};

always_comb begin
	use_imm = 1'b0;
	writes = 1'b0;
	sets_cc = 1'b0;
	is_br = 1'b0;
	alu_op = alu_add;
	case (opcode)
		op_add, op_and: begin
			use_imm = if_instr[5];
			writes = 1'b1;
			sets_cc = 1'b1;
			alu_op = (opcode == op_add) ? alu_add : alu_and;
		end
		op_not: begin
			writes = 1'b1;
			sets_cc = 1'b1;
			alu_op = alu_not;
		end
		op_lea: begin
			writes = 1'b1;
			alu_op = alu_pass;
		end
		op_br: is_br = 1'b1;
		default: ;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		ex_valid <= 1'b0;
		ex_writes <= 1'b0;
		ex_sets_cc <= 1'b0;
		ex_is_br <= 1'b0;
	end else begin
		ex_valid <= if_valid && !flush;
		ex_writes <= writes;
		ex_sets_cc <= sets_cc;
		ex_is_br <= is_br;
	end
end

always_ff @(posedge clk) begin
	ex_sr1 <= src_a;
	ex_sr2 <= src_b;
	ex_dest <= if_instr[11:9];
	ex_nzp <= if_instr[11:9];
	ex_a <= rd_a;
	ex_b <= rd_b;
	ex_imm <= imm5;
	ex_offset <= offset9;
	ex_pc <= if_pc;
	ex_use_imm <= use_imm;
	ex_alu_op <= alu_op;
end

endmodule : lc3b_decode

// ==== logic/lc3b_forward.sv ====
`timescale 1ns/1ns

module lc3b_forward import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_reg ex_sr1,
	input lc3b_reg ex_sr2,
	input logic ex_use_imm,
	input logic mem_valid,
	input logic mem_writes,
	input lc3b_reg mem_dest,
	input logic wb_valid,
	input logic wb_writes,
	input lc3b_reg wb_dest,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b
);

logic mem_hit_ok;
logic wb_hit_ok;

assign mem_hit_ok = mem_valid && mem_writes;
assign wb_hit_ok = wb_valid && wb_writes;

// youngest producer wins
function automatic logic [1:0] pick(lc3b_reg src);
	if (mem_hit_ok && mem_dest == src)
		return fwd_mem;
	else if (wb_hit_ok && wb_dest == src)
		return fwd_wb;
	return fwd_reg;
endfunction

always_comb fwd_a = pick(ex_sr1);
always_comb fwd_b = ex_use_imm ? fwd_reg : pick(ex_sr2);

endmodule : lc3b_forward

// ==== logic/lc3b_execute.sv ====
`timescale 1ns/1ns

module lc3b_execute import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic ex_valid,
	input lc3b_reg ex_dest,
	input lc3b_word ex_a,
	input lc3b_word ex_b,
	input lc3b_word ex_imm,
	input lc3b_word ex_offset,
	input lc3b_word ex_pc,
	input logic ex_use_imm,
	input logic ex_writes,
	input logic ex_sets_cc,
	input logic ex_is_br,
	input lc3b_nzp ex_nzp,
	input lc3b_alu_op ex_alu_op,
	input logic [1:0] fwd_a,
	input logic [1:0] fwd_b,
	input lc3b_word wb_data,
	input logic flush,
	output logic mem_valid,
	output logic mem_writes,
	output logic mem_sets_cc,
	output logic mem_is_br,
	output lc3b_reg mem_dest,
	output lc3b_nzp mem_nzp,
	output lc3b_word mem_result,
	output lc3b_word mem_target
);

lc3b_word op_a;
lc3b_word op_b;
lc3b_word target;
lc3b_word alu_out;

function automatic lc3b_word operand(logic [1:0] sel, lc3b_word reg_val);
	case (sel)
		fwd_mem: return mem_result;
		fwd_wb: return wb_data;
		default: return reg_val;
	endcase
endfunction

always_comb op_a = operand(fwd_a, ex_a);
always_comb op_b = ex_use_imm ? ex_imm : operand(fwd_b, ex_b);

// pc of the instruction plus 2, then the byte offset
assign target = ex_pc + 16'd2 + ex_offset;

always_comb begin
	case (ex_alu_op)
		alu_add: alu_out = op_a + op_b;
		alu_and: alu_out = op_a & op_b;
		alu_not: alu_out = ~op_a;
		default: alu_out = target;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		mem_valid <= 1'b0;
		mem_writes <= 1'b0;
		mem_sets_cc <= 1'b0;
		mem_is_br <= 1'b0;
	end else begin
		mem_valid <= ex_valid && !flush;
		mem_writes <= ex_writes;
		mem_sets_cc <= ex_sets_cc;
		mem_is_br <= ex_is_br;
	end
end

always_ff @(posedge clk) begin
	mem_dest <= ex_dest;
	mem_nzp <= ex_nzp;
	mem_result <= alu_out;
	mem_target <= target;
end

endmodule : lc3b_execute

// ==== logic/lc3b_retire.sv ====
`timescale 1ns/1ns

module lc3b_retire import lc3b_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic mem_valid,
	input logic mem_writes,
	input logic mem_sets_cc,
	input logic mem_is_br,
	input lc3b_reg mem_dest,
	input lc3b_nzp mem_nzp,
	input lc3b_word mem_result,
	input lc3b_word mem_target,
	output logic redirect,
	output lc3b_word redirect_pc,
	output logic flush,
	output logic wb_valid,
	output logic wb_writes,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data,
	output lc3b_reg wb_reg
);

lc3b_nzp cc;
lc3b_nzp gen_nzp;
logic taken;

always_comb begin
	if (mem_result[15])
		gen_nzp = 3'b100;
	else if (mem_result == 16'h0000)
		gen_nzp = 3'b010;
	else
		gen_nzp = 3'b001;
end

// comes out of reset as Z
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n)
		cc <= 3'b010;
	else if (mem_valid && mem_sets_cc)
		cc <= gen_nzp;
end

assign taken = mem_valid && mem_is_br && |(mem_nzp & cc);
assign redirect = taken;
assign redirect_pc = mem_target;
// squashes IF/ID, ID/EX and EX/MEM at the next edge
assign flush = taken;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		wb_valid <= 1'b0;
		wb_writes <= 1'b0;
	end else begin
		wb_valid <= mem_valid;
		wb_writes <= mem_valid && mem_writes;
	end
end

always_ff @(posedge clk) begin
	wb_dest <= mem_dest;
	wb_data <= mem_result;
end

assign wb_reg = wb_dest;

endmodule : lc3b_retire

// ==== logic/lc3b_datapath.sv ====
`timescale 1ns/1ns

module lc3b_datapath import lc3b_pkg::*; #(
	parameter lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic arst_n,
	input lc3b_word fetch_instr,
	output lc3b_word fetch_addr,
	output logic wb_valid,
	output lc3b_reg wb_reg,
	output lc3b_word wb_data
);

logic redirect, flush, if_valid;
lc3b_word redirect_pc, if_instr, if_pc, rd_a, rd_b;
lc3b_reg src_a, src_b, ex_sr1, ex_sr2, ex_dest;
lc3b_word ex_a, ex_b, ex_imm, ex_offset, ex_pc;
logic ex_valid, ex_use_imm, ex_writes, ex_sets_cc, ex_is_br;
lc3b_nzp ex_nzp, mem_nzp;
lc3b_alu_op ex_alu_op;
logic [1:0] fwd_a, fwd_b;
logic mem_valid, mem_writes, mem_sets_cc, mem_is_br;
lc3b_reg mem_dest, wb_dest;
lc3b_word mem_result, mem_target;
logic wb_stage_valid, wb_writes;

// only retiring writes are reported
assign wb_valid = wb_writes;

lc3b_fetch #(.reset_pc(reset_pc)) lc3b_fetch_inst (
	.clk, .arst_n, .fetch_instr, .redirect, .redirect_pc,
	.fetch_addr, .if_valid, .if_instr, .if_pc
);

lc3b_regfile lc3b_regfile_inst (
	.clk, .arst_n, .src_a, .src_b,
	.wr_en(wb_writes), .wr_reg(wb_dest), .wr_data(wb_data),
	.rd_a, .rd_b
);

lc3b_decode lc3b_decode_inst (
	.clk, .arst_n, .if_valid, .if_instr, .if_pc, .rd_a, .rd_b, .flush,
	.src_a, .src_b, .ex_sr1, .ex_sr2, .ex_dest,
	.ex_a, .ex_b, .ex_imm, .ex_offset, .ex_pc,
	.ex_valid, .ex_use_imm, .ex_writes, .ex_sets_cc, .ex_is_br, .ex_nzp, .ex_alu_op
);

lc3b_forward lc3b_forward_inst (
	.clk, .arst_n, .ex_sr1, .ex_sr2, .ex_use_imm,
	.mem_valid, .mem_writes, .mem_dest,
	.wb_valid(wb_stage_valid), .wb_writes, .wb_dest,
	.fwd_a, .fwd_b
);

lc3b_execute lc3b_execute_inst (
	.clk, .arst_n, .ex_valid, .ex_dest, .ex_a, .ex_b, .ex_imm, .ex_offset, .ex_pc,
	.ex_use_imm, .ex_writes, .ex_sets_cc, .ex_is_br, .ex_nzp, .ex_alu_op,
	.fwd_a, .fwd_b, .wb_data, .flush,
	.mem_valid, .mem_writes, .mem_sets_cc, .mem_is_br,
	.mem_dest, .mem_nzp, .mem_result, .mem_target
);

lc3b_retire lc3b_retire_inst (
	.clk, .arst_n, .mem_valid, .mem_writes, .mem_sets_cc, .mem_is_br,
	.mem_dest, .mem_nzp, .mem_result, .mem_target,
	.redirect, .redirect_pc, .flush,
	.wb_valid(wb_stage_valid), .wb_writes, .wb_dest, .wb_data, .wb_reg
);

endmodule : lc3b_datapath

// ==== verification/lc3b_asserts.sv ====
`timescale 1ns/1ns

module lc3b_asserts import lc3b_pkg::*; #(
	parameter lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic arst_n,
	input lc3b_word fetch_addr,
	input logic wb_valid
);

// a cycle held in reset leaves nothing retiring
wb_quiet_in_reset: assert property (@(posedge clk) !arst_n |=> !wb_valid)
	else $error("wb_valid high after a cycle in reset");

fetch_addr_even: assert property (@(posedge clk) disable iff (!arst_n) !fetch_addr[0])
	else $error("odd fetch_addr %h", fetch_addr);

fetch_starts_at_reset_pc: assert property (
	@(posedge clk) $rose(arst_n) |-> fetch_addr == reset_pc
) else $error("fetch_addr %h after reset, expected %h", fetch_addr, reset_pc);

endmodule : lc3b_asserts

bind lc3b_datapath lc3b_asserts #(.reset_pc(reset_pc)) lc3b_asserts_inst (
	.clk(clk),
	.arst_n(arst_n),
	.fetch_addr(fetch_addr),
	.wb_valid(wb_valid)
);

// ==== verification/lc3b_tb.sv ====
`timescale 1ns/1ns

module lc3b_tb import lc3b_pkg::*; ();

localparam lc3b_word reset_pc = 16'h0000;
localparam int prog_len = 22;
localparam int num_rows = 12;
localparam int timeout_ns = (2 * prog_len + 8) * 4;

localparam lc3b_word program_rom [prog_len] = '{
	16'h1225, // add r1, r0, #5
	16'h147d, // add r2, r1, #-3
	16'h1642, // add r3, r1, r2
	16'h5843, // and r4, r1, r3
	16'h9b3f, // not r5, r4
	16'h5d7e, // and r6, r5, #-2
	16'heffc, // lea r7, #-4
	16'h0202, // brp #2, cc still n from the and
	16'h13a1, // add r1, r6, #1
	16'h0803, // brn #3 to 0x1a
	16'h14a1, // add r2, r2, #1 (squashed)
	16'h14a1,
	16'h14a1,
	16'h5082, // and r0, r2, r2
	16'h0dfe, // brnz #-2, falls through
	16'h1603, // add r3, r0, r3
	16'h0603, // brzp #3 to 0x28
	16'h993f, // not r4, r4 (squashed)
	16'h14a1,
	16'h14a1,
	16'h1ae0, // add r5, r3, #0
	16'h1d42  // add r6, r5, r2
};

// {register, data} in retire order
localparam logic [18:0] expect_rows [num_rows] = '{
	{3'd1, 16'h0005}, {3'd2, 16'h0002}, {3'd3, 16'h0007}, {3'd4, 16'h0005},
	{3'd5, 16'hfffa}, {3'd6, 16'hfffa}, {3'd7, 16'h0006}, {3'd1, 16'hfffb},
	{3'd0, 16'h0002}, {3'd3, 16'h0009}, {3'd5, 16'h0009}, {3'd6, 16'h000b}
};

logic clk;
logic arst_n;
lc3b_word fetch_instr;
lc3b_word fetch_addr;
logic wb_valid;
lc3b_reg wb_reg;
lc3b_word wb_data;
lc3b_word imem [256];
int errors = 0;

lc3b_datapath #(.reset_pc(reset_pc)) lc3b_datapath_inst (
	.clk(clk),
	.arst_n(arst_n),
	.fetch_instr(fetch_instr),
	.fetch_addr(fetch_addr),
	.wb_valid(wb_valid),
	.wb_reg(wb_reg),
	.wb_data(wb_data)
);

// word-addressed, answers in the same cycle
assign fetch_instr = imem[fetch_addr[8:1]];

always #2 clk = ~clk;

task automatic check_value(input logic [15:0] got, input logic [15:0] want, input string what);
	if (got !== want) begin
		$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want);
		errors++;
	end
endtask

initial begin
	#(timeout_ns);
	$display("timeout: the expected writebacks never arrived");
	$display("Simulation failed");
	$finish;
end

initial begin
	int passed;
	int waits;
	int errors_before;
	logic [18:0] row;
	passed = 0;
	clk = 1'b0;
	arst_n = 1'b0;
	for (int a = 0; a < 256; a++)
		imem[a] = nop_instr;
	for (int i = 0; i < prog_len; i++)
		imem[i] = program_rom[i];
	repeat (3) @(posedge clk);
	arst_n <= 1'b1;
	@(negedge clk);
	check_value(fetch_addr, reset_pc, "fetch_addr after reset");
	check_value({15'd0, wb_valid}, 16'd0, "wb_valid after reset");
	for (int i = 0; i < num_rows; i++) begin
		row = expect_rows[i];
		errors_before = errors;
		waits = 1;
		@(negedge clk);
		while (wb_valid !== 1'b1) begin
			@(negedge clk);
			waits++;
		end
		// fetched in cycle 0, retires in cycle 4
		if (i == 0)
			check_value(16'(waits), 16'd4, "cycles to first retire");
		check_value({13'd0, wb_reg}, {13'd0, row[18:16]}, $sformatf("row %0d register", i));
		check_value(wb_data, row[15:0], $sformatf("row %0d data", i));
		if (errors == errors_before) begin
			passed++;
			$display("row %0d: r%0d = %h ok", i, wb_reg, wb_data);
		end else begin
			$display("row %0d: r%0d = %h wrong", i, wb_reg, wb_data);
		end
	end
	$display("%0d rows checked, %0d passed, %0d failed, %0d errors",
		num_rows, passed, num_rows - passed, errors);
	if (errors == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

endmodule : lc3b_tb

// ==== vlog.f ====
logic/lc3b_pkg.sv
logic/lc3b_fetch.sv
logic/lc3b_regfile.sv
logic/lc3b_decode.sv
logic/lc3b_forward.sv
logic/lc3b_execute.sv
logic/lc3b_retire.sv
logic/lc3b_datapath.sv
verification/lc3b_asserts.sv
verification/lc3b_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the lc3b pipeline testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module lc3b_tb --Mdir obj_dir -f vlog.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vlc3b_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
